// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////////////////////////

    localparam int addr_w   = 32;
    localparam int index_w  = 4;
    localparam int offset_w = 2;
    localparam int ways     = 2;
    localparam int word_w   = 32;

    // byte offset bits plus word offset bits
    localparam int line_lsb = offset_w + 2;
    localparam int tag_w    = addr_w - index_w - line_lsb;
    localparam int line_w   = word_w << offset_w;
    localparam int sets     = 1 << index_w;

    //////////////////////////////////////////////////////////////////////
    // array entries
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    typedef logic [line_w-1:0] line_t;

    //////////////////////////////////////////////////////////////////////
    // fetch port and memory bus
    //////////////////////////////////////////////////////////////////////

    // inval set means address is ignored, whole cache is cleared
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              uncached;
        logic              inval;
    } fetch_req_t;

    // insn low half is the word at pc, high half valid when pair set
    typedef struct packed {
        logic [addr_w-1:0]   pc;
        logic [2*word_w-1:0] insn;
        logic                pair;
    } fetch_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              single;
    } bus_req_t;

    // single word reads land in the low word
    typedef struct packed {
        line_t data;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/cache_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

// one way of tag or line storage, registered read
module cache_ram #(
    parameter type entry_t = logic
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire [icache_pkg::index_w-1:0]   rd_index,
    output entry_t                          rd_entry,
    input  wire                             wr_en,
    input  wire [icache_pkg::index_w-1:0]   wr_index,
    input  wire entry_t                     wr_entry,
    input  wire                             clear
);

    entry_t mem [icache_pkg::sets];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < icache_pkg::sets; i++) begin
                mem[i] <= '0;
            end
            rd_entry <= '0;
        end else begin
            // clear wins over a write in the same cycle
            if (clear) begin
                for (int i = 0; i < icache_pkg::sets; i++) begin
                    mem[i] <= '0;
                end
            end else if (wr_en) begin
                mem[wr_index] <= wr_entry;
            end
            rd_entry <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             req_valid,
    output logic                            req_ready,
    input  wire icache_pkg::fetch_req_t     req,
    input  wire [icache_pkg::ways-1:0]      hit,
    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output icache_pkg::fetch_req_t          rbuf,
    output logic                            bus_valid,
    input  wire                             bus_ready,
    input  wire                             bus_rsp_valid,
    output logic [icache_pkg::ways-1:0]     tag_we,
    output logic [icache_pkg::ways-1:0]     line_we,
    output logic                            clear,
    output logic                            use_refill,
    output logic                            refill_way,
    output logic                            hit_way
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_bus,
        st_wait,
        st_rsp,
        st_inval
    } state_t;

    state_t                                         state;
    state_t                                         state_nxt;
    logic                                           accept;
    logic                                           refill_done;
    logic                                           victim;
    logic [icache_pkg::index_w-1:0]                 rbuf_index;
    // lru bit points at the way to evict next
    logic [icache_pkg::sets-1:0]                    lru;
    logic [icache_pkg::sets-1:0][icache_pkg::ways-1:0] way_valid;

    assign rbuf_index  = rbuf.addr[icache_pkg::line_lsb +: icache_pkg::index_w];
    assign req_ready   = (state == st_idle) || (state == st_rsp && rsp_ready);
    assign accept      = req_valid && req_ready;
    assign rsp_valid   = (state == st_rsp);
    assign bus_valid   = (state == st_bus);
    assign clear       = (state == st_inval);
    assign use_refill  = (state == st_wait);
    assign hit_way     = hit[1];
    assign refill_done = (state == st_wait) && bus_rsp_valid && !rbuf.uncached;

    // empty way first, then lru
    always_comb begin
        if (!way_valid[rbuf_index][0]) begin
            victim = 1'b0;
        end else if (!way_valid[rbuf_index][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru[rbuf_index];
        end
    end

    always_comb begin
        tag_we = '0;
        if (refill_done) begin
            tag_we[refill_way] = 1'b1;
        end
    end

    assign line_we = tag_we;

    //////////////////////////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle, st_rsp: begin
                if (accept) begin
                    if (req.inval) begin
                        state_nxt = st_inval;
                    end else if (req.uncached) begin
                        state_nxt = st_bus;
                    end else begin
                        state_nxt = st_lookup;
                    end
                end else if (state == st_rsp && rsp_ready) begin
                    state_nxt = st_idle;
                end
            end
            st_lookup: state_nxt = (|hit) ? st_rsp : st_bus;
            st_bus:    state_nxt = bus_ready ? st_wait : st_bus;
            st_wait:   state_nxt = bus_rsp_valid ? st_rsp : st_wait;
            st_inval:  state_nxt = st_rsp;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            lru        <= '0;
            way_valid  <= '0;
            refill_way <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_lookup) begin
                if (|hit) begin
                    lru[rbuf_index] <= ~hit_way;
                end else begin
                    refill_way <= victim;
                end
            end
            if (refill_done) begin
                lru[rbuf_index]                 <= ~refill_way;
                way_valid[rbuf_index][refill_way] <= 1'b1;
            end
            if (clear) begin
                way_valid <= '0;
            end
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf <= req;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             req_valid,
    output logic                            req_ready,
    input  wire icache_pkg::fetch_req_t     req,
    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output icache_pkg::fetch_rsp_t          rsp,
    output logic                            bus_valid,
    input  wire                             bus_ready,
    output icache_pkg::bus_req_t            bus_req,
    input  wire                             bus_rsp_valid,
    input  wire icache_pkg::bus_rsp_t       bus_rsp
);

    logic [icache_pkg::index_w-1:0]     rd_index;
    logic [icache_pkg::index_w-1:0]     wr_index;
    logic [icache_pkg::offset_w-1:0]    rbuf_offset;
    logic [icache_pkg::tag_w-1:0]       rbuf_tag;
    icache_pkg::fetch_req_t             rbuf;
    icache_pkg::tag_entry_t             tag_rd [icache_pkg::ways];
    icache_pkg::line_t                  line_rd [icache_pkg::ways];
    icache_pkg::tag_entry_t             tag_wr;
    logic [icache_pkg::ways-1:0]        hit;
    logic [icache_pkg::ways-1:0]        tag_we;
    logic [icache_pkg::ways-1:0]        line_we;
    logic                               clear;
    logic                               use_refill;
    logic                               hit_way;
    icache_pkg::line_t                  line_sel;
    logic [2*icache_pkg::word_w-1:0]    pair_data;
    logic [icache_pkg::word_w-1:0]      word;
    icache_pkg::fetch_rsp_t             rsp_d;

    // arrays read with the incoming index and compared against the buffered tag
    assign rd_index    = req.addr[icache_pkg::line_lsb +: icache_pkg::index_w];
    assign wr_index    = rbuf.addr[icache_pkg::line_lsb +: icache_pkg::index_w];
    assign rbuf_offset = rbuf.addr[icache_pkg::line_lsb-1:2];
    assign rbuf_tag    = rbuf.addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign tag_wr      = '{valid: 1'b1, tag: rbuf_tag};

    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        cache_ram #(
            .entry_t (icache_pkg::tag_entry_t)
        ) i_tag_ram (
            .clk      (clk),
            .arst_n   (arst_n),
            .rd_index (rd_index),
            .rd_entry (tag_rd[w]),
            .wr_en    (tag_we[w]),
            .wr_index (wr_index),
            .wr_entry (tag_wr),
            .clear    (clear)
        );

        cache_ram #(
            .entry_t (icache_pkg::line_t)
        ) i_line_ram (
            .clk      (clk),
            .arst_n   (arst_n),
            .rd_index (rd_index),
            .rd_entry (line_rd[w]),
            .wr_en    (line_we[w]),
            .wr_index (wr_index),
            .wr_entry (bus_rsp.data),
            .clear    (1'b0)
        );

        assign hit[w] = tag_rd[w].valid && (tag_rd[w].tag == rbuf_tag);
    end

    icache_ctrl i_icache_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .hit           (hit),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rbuf          (rbuf),
        .bus_valid     (bus_valid),
        .bus_ready     (bus_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .tag_we        (tag_we),
        .line_we       (line_we),
        .clear         (clear),
        .use_refill    (use_refill),
        .refill_way    (),
        .hit_way       (hit_way)
    );

    // exact word for uncached reads and the aligned line otherwise
    assign bus_req.addr   = rbuf.uncached ? rbuf.addr
                          : {rbuf.addr[icache_pkg::addr_w-1:icache_pkg::line_lsb],
                             {icache_pkg::line_lsb{1'b0}}};
    assign bus_req.single = rbuf.uncached;

    //////////////////////////////////////////////////////////////////////
    // fetch pair select
    //////////////////////////////////////////////////////////////////////

    assign line_sel  = use_refill ? bus_rsp.data : line_rd[hit_way];
    assign pair_data = line_sel[rbuf_offset[icache_pkg::offset_w-1:1]*2*icache_pkg::word_w
                                +: 2*icache_pkg::word_w];
    assign word      = pair_data[rbuf_offset[0]*icache_pkg::word_w +: icache_pkg::word_w];

    always_comb begin
        rsp_d.pc   = rbuf.addr;
        rsp_d.insn = '0;
        rsp_d.pair = 1'b0;
        if (rbuf.inval) begin
            rsp_d.insn = '0;
        end else if (rbuf.uncached) begin
            rsp_d.insn = {{icache_pkg::word_w{1'b0}}, line_sel[icache_pkg::word_w-1:0]};
        end else if (rbuf_offset[0]) begin
            // partner of an odd word lies in the next pair
            rsp_d.insn = {{icache_pkg::word_w{1'b0}}, word};
        end else begin
            rsp_d.insn = pair_data;
            rsp_d.pair = 1'b1;
        end
    end

    // hold under back-pressure
    always_ff @(posedge clk) begin
        if (!rsp_valid || rsp_ready) begin
            rsp <= rsp_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             i_valid,
    output logic                            i_ready,
    input  wire icache_pkg::bus_req_t       i_req,
    output logic                            i_rsp_valid,
    input  wire                             d_valid,
    output logic                            d_ready,
    input  wire icache_pkg::bus_req_t       d_req,
    output logic                            d_rsp_valid,
    output logic                            mem_req_valid,
    input  wire                             mem_req_ready,
    output icache_pkg::bus_req_t            mem_req,
    input  wire                             mem_rsp_valid
);

    // owner doubles as the last winner for round robin
    logic busy;
    logic owner;
    logic grant_d;
    logic accept;

    always_comb begin
        if (i_valid && d_valid) begin
            grant_d = !owner;
        end else begin
            grant_d = d_valid;
        end
    end

    assign mem_req_valid = !busy && (i_valid || d_valid);
    assign mem_req       = grant_d ? d_req : i_req;
    assign i_ready       = !busy && !grant_d && mem_req_ready;
    assign d_ready       = !busy && grant_d && mem_req_ready;
    assign accept        = mem_req_valid && mem_req_ready;

    // response pulse goes to the owner only
    assign i_rsp_valid = busy && !owner && mem_rsp_valid;
    assign d_rsp_valid = busy && owner && mem_rsp_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (accept) begin
            busy  <= 1'b1;
            owner <= grant_d;
        end else if (mem_rsp_valid) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             req_valid,
    output logic                            req_ready,
    input  wire icache_pkg::fetch_req_t     req,
    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output icache_pkg::fetch_rsp_t          rsp,
    input  wire                             dreq_valid,
    output logic                            dreq_ready,
    input  wire icache_pkg::bus_req_t       dreq,
    output logic                            drsp_valid,
    output icache_pkg::bus_rsp_t            drsp,
    output logic                            mem_req_valid,
    input  wire                             mem_req_ready,
    output icache_pkg::bus_req_t            mem_req,
    input  wire                             mem_rsp_valid,
    input  wire icache_pkg::bus_rsp_t       mem_rsp
);

    logic                   ic_bus_valid;
    logic                   ic_bus_ready;
    icache_pkg::bus_req_t   ic_bus_req;
    logic                   ic_bus_rsp_valid;

    icache i_icache (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .bus_valid     (ic_bus_valid),
        .bus_ready     (ic_bus_ready),
        .bus_req       (ic_bus_req),
        .bus_rsp_valid (ic_bus_rsp_valid),
        .bus_rsp       (mem_rsp)
    );

    mem_arbiter i_mem_arbiter (
        .clk           (clk),
        .arst_n        (arst_n),
        .i_valid       (ic_bus_valid),
        .i_ready       (ic_bus_ready),
        .i_req         (ic_bus_req),
        .i_rsp_valid   (ic_bus_rsp_valid),
        .d_valid       (dreq_valid),
        .d_ready       (dreq_ready),
        .d_req         (dreq),
        .d_rsp_valid   (drsp_valid),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid)
    );

    // response data is shared, only the valid pulse is steered
    assign drsp = mem_rsp;

endmodule

`default_nettype wire

// ==== verif/tb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

// bus slave with random ready and response delay
module tb_mem_model (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire icache_pkg::bus_req_t   req,
    output logic                        rsp_valid,
    output icache_pkg::bus_rsp_t        rsp,
    input  wire                         bd_we,
    input  wire [31:0]                  bd_addr,
    input  wire [31:0]                  bd_data,
    output int                          line_reads,
    output int                          single_reads
);

    logic [31:0]            patched [logic [31:0]];
    logic [31:0]            rng;
    logic [1:0]             delay;
    logic                   busy;
    icache_pkg::bus_req_t   held;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // backdoor writes win over the address pattern
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (patched.exists(a)) begin
            return patched[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic icache_pkg::line_t read_data(input icache_pkg::bus_req_t r);
        logic [31:0] base;
        base = {r.addr[31:4], 4'h0};
        if (r.single) begin
            return {96'h0, word_at(r.addr)};
        end
        return {word_at(base + 12), word_at(base + 8), word_at(base + 4), word_at(base)};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rng          <= 32'd38402;
            req_ready    <= 1'b0;
            rsp_valid    <= 1'b0;
            rsp          <= '0;
            busy         <= 1'b0;
            delay        <= 2'd0;
            held         <= '0;
            line_reads   <= 0;
            single_reads <= 0;
        end else begin
            rng       <= xorshift(rng);
            rsp_valid <= 1'b0;
            if (bd_we) begin
                patched[{bd_addr[31:2], 2'b00}] = bd_data;
            end
            if (req_valid && req_ready) begin
                held      <= req;
                busy      <= 1'b1;
                req_ready <= 1'b0;
                delay     <= rng[1:0];
                if (req.single) begin
                    single_reads <= single_reads + 1;
                end else begin
                    line_reads <= line_reads + 1;
                end
            end else if (busy) begin
                if (delay == 2'd0) begin
                    rsp_valid <= 1'b1;
                    rsp.data  <= read_data(held);
                    busy      <= 1'b0;
                end else begin
                    delay <= delay - 2'd1;
                end
            end else begin
                // ready about three cycles in four
                req_ready <= rng[2] | rng[3];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top;

    // sum of the worst case cycle counts of the tests
    localparam int watchdog_cycles = 2000 + 2000 + 3000 + 3000 + 10000;

    logic                       clk;
    logic                       arst_n;
    logic                       req_valid;
    logic                       req_ready;
    icache_pkg::fetch_req_t     req;
    logic                       rsp_valid;
    logic                       rsp_ready;
    icache_pkg::fetch_rsp_t     rsp;
    logic                       dreq_valid;
    logic                       dreq_ready;
    icache_pkg::bus_req_t       dreq;
    logic                       drsp_valid;
    icache_pkg::bus_rsp_t       drsp;
    logic                       mem_req_valid;
    logic                       mem_req_ready;
    icache_pkg::bus_req_t       mem_req;
    logic                       mem_rsp_valid;
    icache_pkg::bus_rsp_t       mem_rsp;
    logic                       bd_we;
    logic [31:0]                bd_addr;
    logic [31:0]                bd_data;
    int                         line_reads;
    int                         single_reads;
    logic [31:0]                rng;
    logic                       stall_on;
    int                         errors;
    int                         checks;
    // own copy of every backdoor write
    logic [31:0]                written [logic [31:0]];

    fetch_top i_fetch_top (.*);

    tb_mem_model i_mem_model (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (mem_req_valid),
        .req_ready    (mem_req_ready),
        .req          (mem_req),
        .rsp_valid    (mem_rsp_valid),
        .rsp          (mem_rsp),
        .bd_we        (bd_we),
        .bd_addr      (bd_addr),
        .bd_data      (bd_data),
        .line_reads   (line_reads),
        .single_reads (single_reads)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (written.exists(a)) begin
            return written[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic icache_pkg::fetch_rsp_t expected_rsp(input logic [31:0] addr,
                                                            input logic unc);
        icache_pkg::fetch_rsp_t r;
        r.pc   = addr;
        r.insn = {32'h0, expected_word(addr)};
        r.pair = 1'b0;
        // even word of a cached fetch brings its partner
        if (!unc && !addr[2]) begin
            r.insn[63:32] = expected_word(addr + 4);
            r.pair        = 1'b1;
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic poke(input logic [31:0] addr, input logic [31:0] data);
        bd_addr <= addr;
        bd_data <= data;
        bd_we   <= 1'b1;
        @(posedge clk);
        bd_we <= 1'b0;
        written[{addr[31:2], 2'b00}] = data;
    endtask

    task automatic fetch(input logic [31:0] addr, input logic unc, input logic inv,
                         output icache_pkg::fetch_rsp_t got);
        req.addr     <= addr;
        req.uncached <= unc;
        req.inval    <= inv;
        req_valid    <= 1'b1;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!(rsp_valid && rsp_ready));
        got = rsp;
    endtask

    // a negative count skips that bus read check
    task automatic fetch_checked(input logic [31:0] addr, input logic unc, input logic inv,
                                 input icache_pkg::fetch_rsp_t exp, input int lines,
                                 input int singles);
        int                     lines0;
        int                     singles0;
        icache_pkg::fetch_rsp_t got;
        lines0   = line_reads;
        singles0 = single_reads;
        fetch(addr, unc, inv, got);
        check("rsp.pc", 128'(got.pc), 128'(exp.pc));
        check("rsp.insn", 128'(got.insn), 128'(exp.insn));
        check("rsp.pair", 128'(got.pair), 128'(exp.pair));
        if (lines >= 0) begin
            check("line reads", 128'(line_reads - lines0), 128'(lines));
        end
        if (singles >= 0) begin
            check("single reads", 128'(single_reads - singles0), 128'(singles));
        end
    endtask

    task automatic drive_ready();
        logic [31:0] r;
        forever begin
            @(posedge clk);
            r = next_random();
            rsp_ready <= !stall_on || (r[1:0] == 2'b00);
        end
    endtask

    // a stalled response must stay valid and unchanged
    task automatic watch_hold();
        logic                   held;
        icache_pkg::fetch_rsp_t last;
        held = 1'b0;
        forever begin
            @(posedge clk);
            if (held) begin
                check("rsp_valid", 128'(rsp_valid), 128'(1'b1));
                check("rsp", 128'(rsp), 128'(last));
            end
            // no new request taken while the response waits
            if (rsp_valid && !rsp_ready) begin
                check("req_ready", 128'(req_ready), 128'(1'b0));
            end
            held = rsp_valid && !rsp_ready;
            last = rsp;
        end
    endtask

    task automatic data_reads(input int n);
        logic [31:0] r;
        logic [31:0] a;
        for (int i = 0; i < n; i++) begin
            r = next_random();
            a = {16'h0010, r[15:2], 2'b00};
            dreq       <= '{addr: a, single: 1'b1};
            dreq_valid <= 1'b1;
            do begin
                @(posedge clk);
            end while (!dreq_ready);
            dreq_valid <= 1'b0;
            do begin
                @(posedge clk);
            end while (!drsp_valid);
            check("drsp.data", drsp.data, {96'h0, expected_word(a)});
            repeat (int'(r[19:16])) @(posedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////

    task automatic miss_then_hit();
        logic [31:0] a;
        a = 32'h0000_1230;
        fetch_checked(a, 1'b0, 1'b0, expected_rsp(a, 1'b0), 1, 0);
        for (int w = 0; w < 4; w++) begin
            fetch_checked(a + 32'(4 * w), 1'b0, 1'b0, expected_rsp(a + 32'(4 * w), 1'b0), 0, 0);
        end
    endtask

    task automatic uncached_fetch();
        logic [31:0] b;
        b = 32'h0000_2348;
        fetch_checked(b, 1'b1, 1'b0, expected_rsp(b, 1'b1), 0, 1);
        poke(b, 32'hdead_beef);
        fetch_checked(b, 1'b1, 1'b0, expected_rsp(b, 1'b1), 0, 1);
        // not allocated by the uncached reads so this still misses
        fetch_checked(b, 1'b0, 1'b0, expected_rsp(b, 1'b0), 1, 0);
        fetch_checked(b, 1'b0, 1'b0, expected_rsp(b, 1'b0), 0, 0);
    endtask

    task automatic lru_replace();
        logic [31:0] set_a;
        logic [31:0] set_b;
        logic [31:0] set_c;
        set_a = 32'h0001_0060;
        set_b = 32'h0002_0060;
        set_c = 32'h0003_0060;
        fetch_checked(set_a, 1'b0, 1'b0, expected_rsp(set_a, 1'b0), 1, 0);
        fetch_checked(set_b, 1'b0, 1'b0, expected_rsp(set_b, 1'b0), 1, 0);
        fetch_checked(set_a, 1'b0, 1'b0, expected_rsp(set_a, 1'b0), 0, 0);
        // b is least recent here
        fetch_checked(set_c, 1'b0, 1'b0, expected_rsp(set_c, 1'b0), 1, 0);
        fetch_checked(set_a, 1'b0, 1'b0, expected_rsp(set_a, 1'b0), 0, 0);
        fetch_checked(set_b, 1'b0, 1'b0, expected_rsp(set_b, 1'b0), 1, 0);
    endtask

    task automatic invalidate_all();
        logic [31:0]            d;
        icache_pkg::fetch_rsp_t stale;
        icache_pkg::fetch_rsp_t cleared;
        d            = 32'h0000_4470;
        cleared.pc   = d;
        cleared.insn = '0;
        cleared.pair = 1'b0;
        fetch_checked(d, 1'b0, 1'b0, expected_rsp(d, 1'b0), 1, 0);
        stale = expected_rsp(d, 1'b0);
        poke(d, 32'h1234_5678);
        fetch_checked(d, 1'b0, 1'b0, stale, 0, 0);
        fetch_checked(d, 1'b0, 1'b1, cleared, 0, 0);
        fetch_checked(d, 1'b0, 1'b0, expected_rsp(d, 1'b0), 1, 0);
    endtask

    task automatic backpressure_shared_bus();
        logic [31:0] r;
        logic [31:0] a;
        stall_on = 1'b1;
        fork
            data_reads(40);
            begin
                for (int i = 0; i < 40; i++) begin
                    r = next_random();
                    a = {16'h0008, 6'h0, r[9:2], 2'b00};
                    fetch_checked(a, r[12], 1'b0, expected_rsp(a, r[12]), r[12] ? 0 : -1, -1);
                end
            end
        join
        stall_on = 1'b0;
    endtask

    initial begin
        arst_n     <= 1'b0;
        req_valid  <= 1'b0;
        req        <= '0;
        rsp_ready  <= 1'b1;
        dreq_valid <= 1'b0;
        dreq       <= '0;
        bd_we      <= 1'b0;
        bd_addr    <= '0;
        bd_data    <= '0;
        rng        = 32'd38402;
        stall_on   = 1'b0;
        errors     = 0;
        checks     = 0;
        fork
            drive_ready();
            watch_hold();
        join_none
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        miss_then_hit();
        uncached_fetch();
        lru_replace();
        invalidate_all();
        backpressure_shared_bus();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/icache_pkg.sv
verilog/cache_ram.sv
verilog/icache_ctrl.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/fetch_top.sv
verif/tb_mem_model.sv
verif/tb_fetch_top.sv

// ==== Makefile ====
SRCS := $(shell cat flist.f)
SIM  := obj_dir/Vtb_fetch_top

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --top-module tb_fetch_top -Mdir obj_dir -f flist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
